// File: common/uart_defines.svh
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

//------------------------------
// link timing
//------------------------------
// SYS_CLK cycles per bit, kept small for sim
`define UART_CLKS_PER_BIT 16

//------------------------------
// data path and buffering
//------------------------------
`define UART_DATA_W 8         // bits per character
`define UART_FIFO_DEPTH 8     // entries in each fifo

`endif

// File: common/uart_pkg.sv
`default_nettype none

`include "uart_defines.svh"

package uart_pkg;

	// one character on the wire
	typedef logic [`UART_DATA_W-1:0] uart_byte_t;

	// receive side entry, byte plus stop bit check
	typedef struct packed {
		uart_byte_t data;
		logic       frame_err;    // stop bit sampled low
	} rx_item_t;

	// transmitter fsm
	typedef enum logic [1:0] {
		TX_IDLE  = 2'd0,          // waiting on a non-empty fifo
		TX_LOAD  = 2'd1,          // pop strobe, grab head
		TX_SHIFT = 2'd2           // start, data, stop on txd
	} tx_state_t;

	// receiver fsm
	typedef enum logic [1:0] {
		RX_IDLE  = 2'd0,
		RX_START = 2'd1,          // half bit recheck
		RX_DATA  = 2'd2,
		RX_STOP  = 2'd3
	} rx_state_t;

endpackage

`default_nettype wire

// File: fifo/uart_fifo.sv
`default_nettype none

module uart_fifo #(
	parameter type item_t = logic [7:0],   // payload, byte or rx item
	parameter int  DEPTH  = 8
) (
	input  wire logic  SYS_CLK,
	input  wire logic  RST_N,
	input  wire logic  push,
	input  item_t      push_data,
	input  wire logic  pop,
	output item_t      head_data,
	output logic       full,
	output logic       empty
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
	localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(DEPTH);

	//------------------------------
	// storage and pointers
	//------------------------------
	item_t            mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;     // occupancy

	logic do_push;
	logic do_pop;

	assign full    = (count == CNT_FULL);
	assign empty   = (count == '0);
	assign do_push = push && !full;    // push on full is dropped
	assign do_pop  = pop && !empty;    // pop on empty is dropped

	// fall-through read, oldest entry always on the head
	assign head_data = mem[rd_ptr];

	// write port
	always_ff @(posedge SYS_CLK)
	begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	//------------------------------
	// pointer and count update
	//------------------------------
	always_ff @(posedge SYS_CLK or negedge RST_N)
	begin
		if (!RST_N)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;    // wrap
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;          // both or neither
			endcase
		end
	end

endmodule

`default_nettype wire

// File: uart_tx/uart_tx.sv
`default_nettype none

`include "uart_defines.svh"

module uart_tx
	import uart_pkg::*;
(
	input  wire logic  SYS_CLK,
	input  wire logic  RST_N,
	input  wire logic  empty,        // tx fifo has nothing to send
	input  uart_byte_t head_data,
	output logic       pop,
	output logic       txd
);

	localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] BAUD_END = CNT_W'(`UART_CLKS_PER_BIT - 1);

	//------------------------------
	// internal state
	//------------------------------
	tx_state_t        tx_state;
	logic [CNT_W-1:0] baud_cnt;     // cycles within current bit
	logic [3:0]       bit_cnt;      // 0 start, 1..8 data, 9 stop
	uart_byte_t       tx_byte;      // character being sent

	logic baud_end;

	assign baud_end = (baud_cnt == BAUD_END);

	// one cycle strobe to the fifo, head is read the same cycle
	assign pop = (tx_state == TX_LOAD);

	// latch the fifo head while pop is high
	always_ff @(posedge SYS_CLK)
	begin
		if (tx_state == TX_LOAD)
			tx_byte <= head_data;
	end

	//------------------------------
	// baud and bit counters
	//------------------------------
	always_ff @(posedge SYS_CLK or negedge RST_N)
	begin
		if (!RST_N)
		begin
			baud_cnt <= '0;
			bit_cnt  <= '0;
		end
		else if (tx_state == TX_SHIFT)
		begin
			if (baud_end)
			begin
				baud_cnt <= '0;
				bit_cnt  <= bit_cnt + 1'b1;
			end
			else
				baud_cnt <= baud_cnt + 1'b1;
		end
		else
		begin
			baud_cnt <= '0;    // restart on every frame
			bit_cnt  <= '0;
		end
	end

	//------------------------------
	// fsm and line driver
	//------------------------------
	always_ff @(posedge SYS_CLK or negedge RST_N)
	begin
		if (!RST_N)
		begin
			tx_state <= TX_IDLE;
			txd      <= 1'b1;    // line idles high
		end
		else
		begin
			case (tx_state)
				TX_IDLE:
				begin
					txd <= 1'b1;
					if (!empty)
						tx_state <= TX_LOAD;
				end
				TX_LOAD:
				begin
					txd      <= 1'b0;    // start bit, one cycle after pop
					tx_state <= TX_SHIFT;
				end
				TX_SHIFT:
				begin
					if (baud_end)
					begin
						if (bit_cnt == 4'd9)
							tx_state <= TX_IDLE;                  // stop bit done
						else if (bit_cnt <= 4'd7)
							txd <= tx_byte[bit_cnt[2:0]];         // lsb first
						else
							txd <= 1'b1;                          // stop bit
					end
				end
				default:
				begin
					txd      <= 1'b1;
					tx_state <= TX_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: uart_rx/uart_rx.sv
`default_nettype none

`include "uart_defines.svh"

module uart_rx
	import uart_pkg::*;
(
	input  wire logic SYS_CLK,
	input  wire logic RST_N,
	input  wire logic rxd,
	output logic      push,         // one cycle, mid stop bit
	output rx_item_t  push_data
);

	localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] BAUD_END = CNT_W'(`UART_CLKS_PER_BIT - 1);
	localparam logic [CNT_W-1:0] HALF_END = CNT_W'(`UART_CLKS_PER_BIT / 2 - 1);

	//------------------------------
	// input synchronizer
	//------------------------------
	logic rxd_meta;
	logic rxd_sync;
	logic rxd_prev;     // for edge detect

	always_ff @(posedge SYS_CLK or negedge RST_N)
	begin
		if (!RST_N)
		begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
			rxd_prev <= 1'b1;
		end
		else
		begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
			rxd_prev <= rxd_sync;
		end
	end

	rx_state_t        rx_state;
	logic [CNT_W-1:0] baud_cnt;
	logic [2:0]       bit_cnt;      // data bit index
	uart_byte_t       rx_shift;

	logic fall_edge;
	logic data_tick;

	assign fall_edge = rxd_prev && !rxd_sync;
	assign data_tick = (rx_state == RX_DATA) && (baud_cnt == BAUD_END);

	// data bits arrive lsb first, shift in from the top
	always_ff @(posedge SYS_CLK)
	begin
		if (data_tick)
			rx_shift <= {rxd_sync, rx_shift[7:1]};
	end

	//------------------------------
	// frame fsm
	//------------------------------
	always_ff @(posedge SYS_CLK or negedge RST_N)
	begin
		if (!RST_N)
		begin
			rx_state <= RX_IDLE;
			baud_cnt <= '0;
			bit_cnt  <= '0;
			push     <= 1'b0;
		end
		else
		begin
			push <= 1'b0;
			case (rx_state)
				RX_IDLE:
				begin
					baud_cnt <= '0;
					bit_cnt  <= '0;
					if (fall_edge)
						rx_state <= RX_START;
				end
				RX_START:
				begin
					if (baud_cnt == HALF_END)
					begin
						baud_cnt <= '0;
						// still low at half bit, else a glitch
						rx_state <= rxd_sync ? RX_IDLE : RX_DATA;
					end
					else
						baud_cnt <= baud_cnt + 1'b1;
				end
				RX_DATA:
				begin
					if (data_tick)
					begin
						baud_cnt <= '0;
						bit_cnt  <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7)
							rx_state <= RX_STOP;
					end
					else
						baud_cnt <= baud_cnt + 1'b1;
				end
				RX_STOP:
				begin
					if (baud_cnt == BAUD_END)
					begin
						push     <= 1'b1;    // pushed whether stop is good or not
						rx_state <= RX_IDLE;
					end
					else
						baud_cnt <= baud_cnt + 1'b1;
				end
				default: rx_state <= RX_IDLE;
			endcase
		end
	end

	// item payload, set alongside push
	always_ff @(posedge SYS_CLK)
	begin
		if ((rx_state == RX_STOP) && (baud_cnt == BAUD_END))
		begin
			push_data.data      <= rx_shift;
			push_data.frame_err <= !rxd_sync;    // stop bit read low
		end
	end

endmodule

`default_nettype wire

// File: hdl/uart_host_port.sv
`default_nettype none

module uart_host_port
	import uart_pkg::*;
(
	input  wire logic SYS_CLK,
	input  wire logic RST_N,
	// host write side
	input  wire logic tx_req,
	input  uart_byte_t tx_data,
	output logic      tx_ack,
	// tx fifo
	input  wire logic tx_full,
	output logic      tx_push,
	output uart_byte_t tx_push_data,
	// host read side
	output logic      rx_req,
	output uart_byte_t rx_data,
	output logic      rx_frame_err,
	input  wire logic rx_ack,
	// rx fifo
	input  wire logic rx_empty,
	input  rx_item_t  rx_head,
	output logic      rx_pop,
	input  wire logic rx_push,
	input  wire logic rx_full,
	output logic      rx_overrun
);

	logic rx_busy;     // ack seen, waiting for host to drop it

	//------------------------------
	// write handshake
	//------------------------------
	// single push per request, ack then holds until req drops
	assign tx_push      = tx_req && !tx_ack && !tx_full;
	assign tx_push_data = tx_data;

	// read side pops once, same cycle rx_req falls
	assign rx_pop = rx_req && rx_ack;

	always_ff @(posedge SYS_CLK or negedge RST_N)
	begin
		if (!RST_N)
		begin
			tx_ack     <= 1'b0;
			rx_req     <= 1'b0;
			rx_busy    <= 1'b0;
			rx_overrun <= 1'b0;
		end
		else
		begin
			if (tx_push)
				tx_ack <= 1'b1;
			else if (!tx_req)
				tx_ack <= 1'b0;    // phase 4

			//------------------------------
			// read handshake
			//------------------------------
			if (rx_pop)
			begin
				rx_req  <= 1'b0;
				rx_busy <= 1'b1;
			end
			else if (!rx_req && !rx_busy && !rx_empty)
				rx_req <= 1'b1;
			else if (rx_busy && !rx_ack)
				rx_busy <= 1'b0;

			// sticky, item lost at a full fifo
			if (rx_push && rx_full)
				rx_overrun <= 1'b1;
		end
	end

	// head copy held stable while rx_req is up
	always_ff @(posedge SYS_CLK)
	begin
		if (!rx_req && !rx_busy && !rx_empty)
		begin
			rx_data      <= rx_head.data;
			rx_frame_err <= rx_head.frame_err;
		end
	end

endmodule

`default_nettype wire

// File: hdl/uart_link_top.sv
`default_nettype none

`include "uart_defines.svh"

module uart_link_top
	import uart_pkg::*;
(
	input  wire logic SYS_CLK,
	input  wire logic RST_N,
	input  wire logic tx_req,
	input  uart_byte_t tx_data,
	output logic      tx_ack,
	output logic      rx_req,
	output uart_byte_t rx_data,
	output logic      rx_frame_err,
	input  wire logic rx_ack,
	output logic      rx_overrun,
	output logic      txd,
	input  wire logic rxd
);

	//------------------------------
	// transmit path wires
	//------------------------------
	logic       tx_push;
	uart_byte_t tx_push_data;
	logic       tx_pop;
	uart_byte_t tx_head;
	logic       tx_full;
	logic       tx_empty;

	// receive path wires
	logic     rx_push;
	rx_item_t rx_push_data;
	logic     rx_pop;
	rx_item_t rx_head;
	logic     rx_full;
	logic     rx_empty;

	uart_host_port u_host_port (
		.SYS_CLK      (SYS_CLK),
		.RST_N        (RST_N),
		.tx_req       (tx_req),
		.tx_data      (tx_data),
		.tx_ack       (tx_ack),
		.tx_full      (tx_full),
		.tx_push      (tx_push),
		.tx_push_data (tx_push_data),
		.rx_req       (rx_req),
		.rx_data      (rx_data),
		.rx_frame_err (rx_frame_err),
		.rx_ack       (rx_ack),
		.rx_empty     (rx_empty),
		.rx_head      (rx_head),
		.rx_pop       (rx_pop),
		.rx_push      (rx_push),
		.rx_full      (rx_full),
		.rx_overrun   (rx_overrun)
	);

	uart_fifo #(.item_t(uart_byte_t), .DEPTH(`UART_FIFO_DEPTH)) u_tx_fifo (
		.SYS_CLK   (SYS_CLK),
		.RST_N     (RST_N),
		.push      (tx_push),
		.push_data (tx_push_data),
		.pop       (tx_pop),
		.head_data (tx_head),
		.full      (tx_full),
		.empty     (tx_empty)
	);

	uart_tx u_tx (
		.SYS_CLK   (SYS_CLK),
		.RST_N     (RST_N),
		.empty     (tx_empty),
		.head_data (tx_head),
		.pop       (tx_pop),
		.txd       (txd)
	);

	uart_rx u_rx (
		.SYS_CLK   (SYS_CLK),
		.RST_N     (RST_N),
		.rxd       (rxd),
		.push      (rx_push),
		.push_data (rx_push_data)
	);

	// rx side buffer, overrun is flagged in the host port
	uart_fifo #(.item_t(rx_item_t), .DEPTH(`UART_FIFO_DEPTH)) u_rx_fifo (
		.SYS_CLK   (SYS_CLK),
		.RST_N     (RST_N),
		.push      (rx_push),
		.push_data (rx_push_data),
		.pop       (rx_pop),
		.head_data (rx_head),
		.full      (rx_full),
		.empty     (rx_empty)
	);

endmodule

`default_nettype wire

// File: bench/uart_link_assert.sv
`default_nettype none

module uart_link_assert (
	input wire logic SYS_CLK,
	input wire logic RST_N,
	input wire logic tx_req,
	input wire logic tx_ack,
	input wire logic rx_req,
	input wire logic rx_ack,
	input wire logic txd
);

	int fail_cnt = 0;    // read back by the testbench at the end

	//------------------------------
	// host handshakes
	//------------------------------
	// write ack only answers a live request
	tx_ack_needs_req: assert property (@(posedge SYS_CLK) disable iff (!RST_N)
		$rose(tx_ack) |-> $past(tx_req))
	else
	begin
		$error("tx_ack rose with tx_req low");
		fail_cnt++;
	end

	// read request is withdrawn only after the host acks
	rx_req_held: assert property (@(posedge SYS_CLK) disable iff (!RST_N)
		rx_req && !rx_ack |=> rx_req)
	else
	begin
		$error("rx_req dropped before rx_ack");
		fail_cnt++;
	end

	// line stays idle high while in reset
	txd_idle_in_reset: assert property (@(posedge SYS_CLK) !RST_N |-> txd)
	else
	begin
		$error("txd low during reset");
		fail_cnt++;
	end

endmodule

bind uart_link_top uart_link_assert u_assert (
	.SYS_CLK (SYS_CLK),
	.RST_N   (RST_N),
	.tx_req  (tx_req),
	.tx_ack  (tx_ack),
	.rx_req  (rx_req),
	.rx_ack  (rx_ack),
	.txd     (txd)
);

`default_nettype wire

// File: bench/uart_link_tb.sv
`default_nettype none

`include "uart_defines.svh"

module uart_link_tb
	import uart_pkg::*;
();

	localparam int FRAME_CYC = 10 * `UART_CLKS_PER_BIT;    // one 8n1 frame
	localparam int RESET_CYC = 16;
	// single, burst, two injected, overrun run
	localparam int N_BYTES = 1 + 2 * `UART_FIFO_DEPTH + 2 + `UART_FIFO_DEPTH + 2;

	//------------------------------
	// dut signals
	//------------------------------
	logic       SYS_CLK;
	logic       RST_N;
	logic       tx_req;
	uart_byte_t tx_data;
	logic       tx_ack;
	logic       rx_req;
	uart_byte_t rx_data;
	logic       rx_frame_err;
	logic       rx_ack;
	logic       rx_overrun;
	logic       txd;
	logic       rxd;

	// rxd mux, loopback unless the injector owns the line
	logic inj_en;
	logic inj_line;

	assign rxd = inj_en ? inj_line : txd;

	rx_item_t exp_q[$];        // expected items in arrival order
	logic     rd_en;           // host side willing to ack
	string    cur_test = "";
	int       errors = 0;
	int       checks = 0;
	int       tests = 0;
	int       test_err0 = 0;   // error count when the test began
	integer   seed;

	uart_link_top u_dut (
		.SYS_CLK      (SYS_CLK),
		.RST_N        (RST_N),
		.tx_req       (tx_req),
		.tx_data      (tx_data),
		.tx_ack       (tx_ack),
		.rx_req       (rx_req),
		.rx_data      (rx_data),
		.rx_frame_err (rx_frame_err),
		.rx_ack       (rx_ack),
		.rx_overrun   (rx_overrun),
		.txd          (txd),
		.rxd          (rxd)
	);

	initial
	begin
		SYS_CLK = 1'b0;
		forever #4 SYS_CLK = ~SYS_CLK;
	end

	// watchdog, every byte twice over plus reset
	initial
	begin
		#(N_BYTES * FRAME_CYC * 8 * 2 + RESET_CYC * 8);
		$display("watchdog expired during test %s", cur_test);
		$display("RESULT: FAIL");
		$finish;
	end

	//------------------------------
	// reference and compare
	//------------------------------
	function automatic rx_item_t expect_item(input uart_byte_t b, input logic stop_bit);
		rx_item_t it;
		it.data      = b;
		it.frame_err = !stop_bit;    // low stop bit
		return it;
	endfunction

	task automatic compare_item(input string name, input rx_item_t exp, input rx_item_t got);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("error %s: expected %h/%b, got %h/%b", name,
				exp.data, exp.frame_err, got.data, got.frame_err);
		end
	endtask

	task automatic compare_flag(input string name, input logic exp, input logic got);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("error %s: expected %b, got %b", name, exp, got);
		end
	endtask

	task automatic begin_test(input string name);
		cur_test  = name;
		test_err0 = errors;
	endtask

	task automatic end_test();
		tests++;
		$display("test %s: %s", cur_test, (errors == test_err0) ? "ok" : "failed");
	endtask

	//------------------------------
	// stimulus tasks
	//------------------------------
	// four-phase write, back-pressure shows up as a late ack
	task automatic write_byte(input uart_byte_t b);
		int n;
		n = 0;
		tx_data <= b;    // held while req is up
		tx_req  <= 1'b1;
		@(posedge SYS_CLK);
		while (!tx_ack && n < 2 * FRAME_CYC)
		begin
			@(posedge SYS_CLK);
			n++;
		end
		if (!tx_ack)
		begin
			errors++;
			$display("%s: no tx_ack for byte %h", cur_test, b);
		end
		tx_req <= 1'b0;
		while (tx_ack)    // wait for phase 4
			@(posedge SYS_CLK);
	endtask

	// one idle bit, then start, data lsb first, stop, then idle
	task automatic inject_frame(input uart_byte_t b, input logic stop_bit);
		logic [9:0] frame;
		frame = {stop_bit, b, 1'b0};
		inj_line <= 1'b1;
		repeat (`UART_CLKS_PER_BIT) @(posedge SYS_CLK);
		repeat (10)
		begin
			inj_line <= frame[0];
			frame = {1'b1, frame[9:1]};
			repeat (`UART_CLKS_PER_BIT) @(posedge SYS_CLK);
		end
		inj_line <= 1'b1;
		repeat (2 * `UART_CLKS_PER_BIT) @(posedge SYS_CLK);
	endtask

	task automatic wait_drain(input int max_cycles);
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < max_cycles)
		begin
			@(posedge SYS_CLK);
			n++;
		end
		if (exp_q.size() != 0)
		begin
			errors++;
			$display("%s: %0d expected items never arrived", cur_test, exp_q.size());
			exp_q.delete();
		end
	endtask

	//------------------------------
	// host read side and compare
	//------------------------------
	initial
	begin
		rx_item_t got;
		rx_item_t exp;
		rx_ack <= 1'b0;
		forever
		begin
			@(posedge SYS_CLK);
			if (rd_en && rx_req && !rx_ack)
			begin
				got.data      = rx_data;
				got.frame_err = rx_frame_err;
				if (exp_q.size() == 0)
				begin
					errors++;
					$display("%s: item %h arrived with none expected", cur_test, got);
				end
				else
				begin
					exp = exp_q.pop_front();
					compare_item(cur_test, exp, got);
				end
				rx_ack <= 1'b1;
			end
			else if (rx_ack && !rx_req)
				rx_ack <= 1'b0;    // req gone, close the handshake
		end
	end

	//------------------------------
	// test sequence
	//------------------------------
	initial
	begin
		uart_byte_t  b;
		logic [31:0] rnd;
		int          n;
		seed      = 32'ha25b7cdc;
		rd_en     = 1'b1;
		RST_N    <= 1'b1;
		tx_req   <= 1'b0;
		tx_data  <= '0;
		inj_en   <= 1'b0;
		inj_line <= 1'b1;
		#2 RST_N <= 1'b0;
		repeat (RESET_CYC) @(posedge SYS_CLK);
		RST_N <= 1'b1;
		@(posedge SYS_CLK);

		begin_test("reset");
		compare_flag("reset txd", 1'b1, txd);
		compare_flag("reset tx_ack", 1'b0, tx_ack);
		compare_flag("reset rx_req", 1'b0, rx_req);
		compare_flag("reset rx_overrun", 1'b0, rx_overrun);
		end_test();

		begin_test("loopback");
		exp_q.push_back(expect_item(8'h5a, 1'b1));
		write_byte(8'h5a);
		wait_drain(3 * FRAME_CYC);
		end_test();

		begin_test("burst");    // twice the fifo depth, tx side fills
		for (int i = 0; i < 2 * `UART_FIFO_DEPTH; i++)
		begin
			rnd = $random(seed);
			b   = rnd[7:0];
			exp_q.push_back(expect_item(b, 1'b1));
			write_byte(b);
		end
		wait_drain((2 * `UART_FIFO_DEPTH + 2) * FRAME_CYC);
		end_test();

		begin_test("framing");
		inj_en <= 1'b1;
		exp_q.push_back(expect_item(8'hc5, 1'b0));
		inject_frame(8'hc5, 1'b0);          // bad stop bit
		exp_q.push_back(expect_item(8'h3a, 1'b1));
		inject_frame(8'h3a, 1'b1);
		wait_drain(2 * FRAME_CYC);
		inj_en <= 1'b0;
		end_test();

		begin_test("overrun");
		rd_en = 1'b0;    // host stops acking
		for (int i = 0; i < `UART_FIFO_DEPTH + 2; i++)
		begin
			rnd = $random(seed);
			b   = rnd[7:0];
			if (i < `UART_FIFO_DEPTH)
				exp_q.push_back(expect_item(b, 1'b1));    // last two get dropped
			write_byte(b);
		end
		n = 0;
		while (!rx_overrun && n < (`UART_FIFO_DEPTH + 3) * FRAME_CYC)
		begin
			@(posedge SYS_CLK);
			n++;
		end
		repeat (2 * FRAME_CYC) @(posedge SYS_CLK);    // last frame off the line
		compare_flag("overrun flag", 1'b1, rx_overrun);
		rd_en = 1'b1;
		wait_drain(2 * FRAME_CYC);
		rd_en = 1'b0;    // a leftover item would keep rx_req high
		repeat (FRAME_CYC) @(posedge SYS_CLK);
		compare_flag("overrun rx empty", 1'b0, rx_req);
		end_test();

		errors = errors + u_dut.u_assert.fail_cnt;
		$display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
			tests, checks, errors, u_dut.u_assert.fail_cnt);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: uart_link_top.f
+incdir+common
common/uart_pkg.sv
fifo/uart_fifo.sv
uart_tx/uart_tx.sv
uart_rx/uart_rx.sv
hdl/uart_host_port.sv
hdl/uart_link_top.sv
bench/uart_link_assert.sv
bench/uart_link_tb.sv

// File: run_sim.sh
#!/bin/sh
# build with verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module uart_link_tb \
	-f uart_link_top.f -Mdir obj_dir -o uart_link_sim \
	&& ./obj_dir/uart_link_sim | tee /dev/stderr | grep -x "RESULT: PASS" > /dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
